// ==== src.f ====
hdl/ctl_pkg.sv
hdl/commit_queue.sv
hdl/commit_ctl_fsm.sv
hdl/maint_sequencer.sv
hdl/commit_ctl_top.sv
tb/commit_ctl_assert.sv
tb/tb_commit_ctl.sv

// ==== Makefile ====
# Verilator build and run of the commit control testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing --assert -f src.f --top-module tb_commit_ctl -Mdir obj_dir -o sim
	./obj_dir/sim > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Something failed" $(LOG) || ! grep -q "Everything OK" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// ==== tb/tb_commit_ctl.sv ====
// Directed testbench for commit_ctl_top with a credit sender and an L2 responder
`timescale 1ns/1ps

module tb_commit_ctl;

	localparam int N_TESTS = 5;
	localparam ctl_pkg::instr_t NOP        = 32'h0000_0013;
	localparam ctl_pkg::instr_t FENCE_I    = 32'h0000_100F;
	localparam ctl_pkg::instr_t SFENCE_VMA = 32'h1200_0073;

	logic                  clk_i;
	logic                  rst_n_i;
	logic                  rec_valid_i;
	ctl_pkg::instr_t       rec_instr_i;
	logic                  rec_except_i;
	ctl_pkg::except_code_t rec_code_i;
	logic                  credit_o;
	logic                  flush_o;
	logic                  abort_o;
	logic                  stall_o;
	logic                  trap_o;
	ctl_pkg::except_code_t trap_cause_o;
	logic                  retire_o;
	logic                  clr_l1tlb_mshr_o;
	logic                  clr_l2tlb_mshr_o;
	logic                  clear_dmshr_o;
	ctl_pkg::tlb_flush_e   l1tlb_flush_type_o;
	ctl_pkg::tlb_flush_e   l2tlb_flush_type_o;
	logic                  synch_l1dc_l2c_o;
	logic                  l2c_update_done_i;

	integer seed;
	int     errors;
	int     tests_run;
	int     credits;
	int     resp_cnt;
	logic   resp_active;

	// Event counters updated at the falling edge
	int n_credit, n_retire, n_flush, n_abort, n_trap, n_clr_tlb, n_clr_d;
	int n_flush_all, n_flush_any, n_sync;
	int last_cause;
	logic prev_sync;
	logic prev_done;

	commit_ctl_top uut (.*);

	bind commit_ctl_top commit_ctl_assert u_assert (
		.clk_i            (clk_i),
		.rst_n_i          (rst_n_i),
		.rec_valid_i      (rec_valid_i),
		.credit_o         (credit_o),
		.stall_o          (stall_o),
		.synch_l1dc_l2c_o (synch_l1dc_l2c_o),
		.cmd_valid_i      (cmd_valid),
		.seq_busy_i       (seq_busy)
	);

	always #5 clk_i = ~clk_i;

	task automatic report_mismatch(input string name, input int got, input int exp);
		$display("FAIL t=%0t %s expected %0d got %0d", $time, name, exp, got);
		errors++;
	endtask

	task automatic report_problem(input string what);
		$display("ERROR t=%0t %s", $time, what);
		errors++;
	endtask

	// Sample just after the falling edge once the monitor has run
	task automatic settle();
		@(negedge clk_i);
		#1;
	endtask

	always @(negedge clk_i) begin
		if (rst_n_i) begin
			if (credit_o) begin
				credits = credits + 1;
				n_credit++;
			end
			if (retire_o) n_retire++;
			if (flush_o) n_flush++;
			if (abort_o) n_abort++;
			if (trap_o) begin
				n_trap++;
				last_cause = int'(trap_cause_o);
			end
			if (clr_l1tlb_mshr_o) n_clr_tlb++;
			if (clear_dmshr_o) n_clr_d++;
			if (l1tlb_flush_type_o == ctl_pkg::FLUSH_ALL) n_flush_all++;
			if (l1tlb_flush_type_o != ctl_pkg::NO_FLUSH) n_flush_any++;
			if (synch_l1dc_l2c_o) n_sync++;
			if (clr_l1tlb_mshr_o != clr_l2tlb_mshr_o) begin
				report_problem("L1 and L2 TLB-MSHR clears are not together");
			end
			if (l1tlb_flush_type_o != l2tlb_flush_type_o) begin
				report_problem("L1 and L2 TLB flush types differ");
			end
			if (prev_sync && !prev_done && !synch_l1dc_l2c_o) begin
				report_problem("cache sync request dropped before the L2 finished");
			end
			if (abort_o && !flush_o) report_problem("abort_o without flush_o");
			prev_sync = synch_l1dc_l2c_o;
			prev_done = l2c_update_done_i;
		end
	end

	// L2 model answering a sync request after 1 to 8 cycles
	always @(posedge clk_i) begin
		if (!rst_n_i) begin
			l2c_update_done_i <= 1'b0;
			resp_active = 1'b0;
		end else if (l2c_update_done_i) begin
			l2c_update_done_i <= 1'b0;
			resp_active = 1'b0;
		end else if (synch_l1dc_l2c_o && !resp_active) begin
			resp_active = 1'b1;
			resp_cnt = 1 + int'($unsigned($random(seed)) % 8);
		end else if (resp_active) begin
			resp_cnt--;
			if (resp_cnt == 0) l2c_update_done_i <= 1'b1;
		end
	end

	task automatic send_rec(input ctl_pkg::instr_t instr, input logic exc,
	                        input ctl_pkg::except_code_t code);
		@(posedge clk_i);
		while (credits == 0) begin
			rec_valid_i <= 1'b0;
			@(posedge clk_i);
		end
		rec_valid_i  <= 1'b1;
		rec_instr_i  <= instr;
		rec_except_i <= exc;
		rec_code_i   <= code;
		credits = credits - 1;
	endtask

	task automatic end_send();
		@(posedge clk_i);
		rec_valid_i  <= 1'b0;
		rec_except_i <= 1'b0;
	endtask

	task automatic wait_idle();
		int cycles;
		cycles = 0;
		settle();
		while (!(credits == ctl_pkg::CQ_DEPTH && !stall_o && !synch_l1dc_l2c_o)) begin
			cycles++;
			if (cycles > 150) begin
				report_problem("unit did not return to idle");
				return;
			end
			settle();
		end
	endtask

	// Expected response from the classification rules
	task automatic expect_action(input ctl_pkg::instr_t instr, input logic exc,
	                             input ctl_pkg::except_code_t code,
	                             output int flush, output int abort, output int trap,
	                             output int cause, output int clr_tlb, output int clr_d,
	                             output int flush_all, output int sync, output int retire);
		flush = 0;
		abort = 0;
		trap = 0;
		cause = 0;
		clr_tlb = 0;
		clr_d = 0;
		flush_all = 0;
		sync = 0;
		retire = 0;
		if (exc) begin
			if (code inside {4'd0, 4'd1, 4'd12}) begin
				flush = 1;
				clr_tlb = 1;
			end else if (code inside {4'd4, 4'd5, 4'd6, 4'd7, 4'd13, 4'd15}) begin
				flush = 1;
				clr_d = 1;
			end else if (code == 4'd2) begin
				flush = 1;
				abort = 1;
			end else begin
				trap = 1;
				cause = int'(code);
			end
		end else if (instr[6:0] == ctl_pkg::OPCODE_MISC_MEM && instr[14:12] == 3'd1) begin
			clr_tlb = 1;
		end else if (instr[6:0] == ctl_pkg::OPCODE_SYSTEM && instr[14:12] == 3'd0 &&
		             instr[31:25] == 7'h09) begin
			clr_tlb = 1;
			clr_d = 1;
			flush_all = 1;
			sync = 1;
		end else if (instr == 32'h0000_0073) begin
			trap = 1;
			cause = 8;
		end else if (instr == 32'h0010_0073) begin
			trap = 1;
			cause = 3;
		end else begin
			retire = 1;
		end
	endtask

	task automatic run_one(input ctl_pkg::instr_t instr, input logic exc,
	                       input ctl_pkg::except_code_t code);
		int e_fl, e_ab, e_tr, e_ca, e_ct, e_cd, e_fa, e_sy, e_re;
		int s_fl, s_ab, s_tr, s_ct, s_cd, s_fa, s_fy, s_sy, s_re;
		int got_sync;
		expect_action(instr, exc, code, e_fl, e_ab, e_tr, e_ca, e_ct, e_cd, e_fa, e_sy, e_re);
		s_fl = n_flush;
		s_ab = n_abort;
		s_tr = n_trap;
		s_ct = n_clr_tlb;
		s_cd = n_clr_d;
		s_fa = n_flush_all;
		s_fy = n_flush_any;
		s_sy = n_sync;
		s_re = n_retire;
		send_rec(instr, exc, code);
		end_send();
		wait_idle();
		got_sync = (n_sync - s_sy) > 0 ? 1 : 0;
		if (n_flush - s_fl != e_fl) report_mismatch("flush_o", n_flush - s_fl, e_fl);
		if (n_abort - s_ab != e_ab) report_mismatch("abort_o", n_abort - s_ab, e_ab);
		if (n_trap - s_tr != e_tr) report_mismatch("trap_o", n_trap - s_tr, e_tr);
		if (e_tr != 0 && last_cause != e_ca) report_mismatch("trap_cause_o", last_cause, e_ca);
		if (n_clr_tlb - s_ct != e_ct) report_mismatch("clr_l1tlb_mshr_o", n_clr_tlb - s_ct, e_ct);
		if (n_clr_d - s_cd != e_cd) report_mismatch("clear_dmshr_o", n_clr_d - s_cd, e_cd);
		if (n_flush_all - s_fa != e_fa) begin
			report_mismatch("l1tlb_flush_type_o FLUSH_ALL", n_flush_all - s_fa, e_fa);
		end
		if (n_flush_any - s_fy != e_fa) begin
			report_mismatch("l1tlb_flush_type_o not NO_FLUSH", n_flush_any - s_fy, e_fa);
		end
		if (got_sync != e_sy) report_mismatch("synch_l1dc_l2c_o", got_sync, e_sy);
		if (n_retire - s_re != e_re) report_mismatch("retire_o", n_retire - s_re, e_re);
	endtask

	task automatic test_reset();
		repeat (5) @(posedge clk_i);
		rst_n_i <= 1'b1;
		@(negedge clk_i);
		if (flush_o !== 1'b1) report_mismatch("flush_o", int'(flush_o), 1);
		if (clr_l1tlb_mshr_o !== 1'b1) report_mismatch("clr_l1tlb_mshr_o", int'(clr_l1tlb_mshr_o), 1);
		if (clr_l2tlb_mshr_o !== 1'b1) report_mismatch("clr_l2tlb_mshr_o", int'(clr_l2tlb_mshr_o), 1);
		if (l1tlb_flush_type_o != ctl_pkg::FLUSH_ALL) begin
			report_mismatch("l1tlb_flush_type_o", int'(l1tlb_flush_type_o), 1);
		end
		if (l2tlb_flush_type_o != ctl_pkg::FLUSH_ALL) begin
			report_mismatch("l2tlb_flush_type_o", int'(l2tlb_flush_type_o), 1);
		end
		settle();
		if (flush_o || abort_o || trap_o || retire_o || credit_o || stall_o) begin
			report_problem("pipeline outputs not idle after the reset clean-up");
		end
		if (clr_l1tlb_mshr_o || clr_l2tlb_mshr_o || clear_dmshr_o || synch_l1dc_l2c_o) begin
			report_problem("memory commands not idle after the reset clean-up");
		end
		if (l1tlb_flush_type_o != ctl_pkg::NO_FLUSH || l2tlb_flush_type_o != ctl_pkg::NO_FLUSH) begin
			report_problem("flush types not NO_FLUSH after the reset clean-up");
		end
		if (credits != ctl_pkg::CQ_DEPTH) report_mismatch("credits", credits, ctl_pkg::CQ_DEPTH);
		tests_run++;
	endtask

	task automatic test_credit_round_trip();
		int s_re;
		int s_cr;
		s_re = n_retire;
		s_cr = n_credit;
		repeat (4) send_rec(NOP, 1'b0, '0);
		end_send();
		wait_idle();
		if (n_retire - s_re != 4) report_mismatch("retire_o", n_retire - s_re, 4);
		if (n_credit - s_cr != 4) report_mismatch("credit_o", n_credit - s_cr, 4);
		if (credits != ctl_pkg::CQ_DEPTH) report_mismatch("credits", credits, ctl_pkg::CQ_DEPTH);
		tests_run++;
	endtask

	task automatic test_exceptions();
		int codes[$];
		codes = '{0, 1, 12, 4, 5, 6, 7, 13, 15, 2, 3, 8, 9, 11, 10};
		foreach (codes[i]) begin
			run_one(NOP, 1'b1, ctl_pkg::except_code_t'(codes[i]));
		end
		tests_run++;
	endtask

	task automatic test_env_calls();
		run_one(ctl_pkg::INSTR_ECALL, 1'b0, '0);
		run_one(ctl_pkg::INSTR_EBREAK, 1'b0, '0);
		tests_run++;
	endtask

	task automatic test_fences();
		int r0;
		int cycles;
		run_one(FENCE_I, 1'b0, '0);
		run_one(SFENCE_VMA, 1'b0, '0);
		// Younger records queued behind the SFENCE.VMA
		r0 = n_retire;
		send_rec(SFENCE_VMA, 1'b0, '0);
		send_rec(NOP, 1'b0, '0);
		send_rec(NOP, 1'b0, '0);
		end_send();
		cycles = 0;
		settle();
		while (!stall_o && cycles < 20) begin
			settle();
			cycles++;
		end
		if (!stall_o) report_problem("stall_o never rose for SFENCE.VMA");
		while (stall_o) begin
			if (n_retire != r0) report_mismatch("retire_o during stall", n_retire - r0, 0);
			settle();
		end
		wait_idle();
		if (n_retire - r0 != 2) report_mismatch("retire_o", n_retire - r0, 2);
		tests_run++;
	endtask

	initial begin
		repeat (N_TESTS * 200) @(posedge clk_i);
		$display("ERROR watchdog expired before the tests completed");
		$display("Something failed");
		$finish;
	end

	initial begin
		seed = 83367;
		errors = 0;
		tests_run = 0;
		credits = ctl_pkg::CQ_DEPTH;
		{n_credit, n_retire, n_flush, n_abort, n_trap} = '0;
		{n_clr_tlb, n_clr_d, n_flush_all, n_flush_any, n_sync} = '0;
		last_cause = 0;
		prev_sync = 1'b0;
		prev_done = 1'b0;
		resp_cnt = 0;
		resp_active = 1'b0;
		clk_i = 1'b0;
		rst_n_i = 1'b0;
		rec_valid_i = 1'b0;
		rec_instr_i = '0;
		rec_except_i = 1'b0;
		rec_code_i = '0;
		l2c_update_done_i = 1'b0;
		test_reset();
		test_credit_round_trip();
		test_exceptions();
		test_env_calls();
		test_fences();
		$display("Tests run: %0d, errors: %0d", tests_run, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

// ==== tb/commit_ctl_assert.sv ====
// Protocol assertions for the commit control unit, bound to the top level
`timescale 1ns/1ps

module commit_ctl_assert (
	input logic clk_i,
	input logic rst_n_i,
	input logic rec_valid_i,
	input logic credit_o,
	input logic stall_o,
	input logic synch_l1dc_l2c_o,
	input logic cmd_valid_i,
	input logic seq_busy_i
);

	// Credits the sender holds
	int credits;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			credits <= ctl_pkg::CQ_DEPTH;
		end else begin
			credits <= credits - int'(rec_valid_i) + int'(credit_o);
		end
	end

	send_needs_credit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		rec_valid_i |-> credits > 0)
		else $error("record sent without a credit");

	cmd_only_when_free: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		cmd_valid_i |-> !seq_busy_i)
		else $error("command issued while the sequencer is busy");

	stall_during_sync: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		synch_l1dc_l2c_o |-> stall_o)
		else $error("cache sync running without a pipeline stall");

endmodule

// ==== hdl/commit_ctl_top.sv ====
// Commit-side control unit top: queue, control FSM and maintenance sequencer
`timescale 1ns/1ps

module commit_ctl_top (
	input  logic                  clk_i,
	input  logic                  rst_n_i,
	// Commit record sender
	input  logic                  rec_valid_i,
	input  ctl_pkg::instr_t       rec_instr_i,
	input  logic                  rec_except_i,
	input  ctl_pkg::except_code_t rec_code_i,
	output logic                  credit_o,
	// Pipeline control
	output logic                  flush_o,
	output logic                  abort_o,
	output logic                  stall_o,
	output logic                  trap_o,
	output ctl_pkg::except_code_t trap_cause_o,
	output logic                  retire_o,
	// Memory system
	output logic                  clr_l1tlb_mshr_o,
	output logic                  clr_l2tlb_mshr_o,
	output logic                  clear_dmshr_o,
	output ctl_pkg::tlb_flush_e   l1tlb_flush_type_o,
	output ctl_pkg::tlb_flush_e   l2tlb_flush_type_o,
	output logic                  synch_l1dc_l2c_o,
	input  logic                  l2c_update_done_i
);

	// Queue head
	logic                  head_valid;
	ctl_pkg::instr_t       head_instr;
	logic                  head_except;
	ctl_pkg::except_code_t head_code;
	logic                  head_pop;

	// FSM to sequencer command
	logic                  cmd_valid;
	logic                  cmd_clr_tlb_mshr;
	logic                  cmd_clr_dmshr;
	ctl_pkg::tlb_flush_e   cmd_tlb_flush;
	logic                  cmd_sync;
	logic                  seq_busy;

	commit_queue u_queue (
		.clk_i         (clk_i),
		.rst_n_i       (rst_n_i),
		.rec_valid_i   (rec_valid_i),
		.rec_instr_i   (rec_instr_i),
		.rec_except_i  (rec_except_i),
		.rec_code_i    (rec_code_i),
		.head_pop_i    (head_pop),
		.head_valid_o  (head_valid),
		.head_instr_o  (head_instr),
		.head_except_o (head_except),
		.head_code_o   (head_code),
		.credit_o      (credit_o)
	);

	commit_ctl_fsm u_fsm (
		.clk_i              (clk_i),
		.rst_n_i            (rst_n_i),
		.head_valid_i       (head_valid),
		.head_instr_i       (head_instr),
		.head_except_i      (head_except),
		.head_code_i        (head_code),
		.head_pop_o         (head_pop),
		.seq_busy_i         (seq_busy),
		.cmd_valid_o        (cmd_valid),
		.cmd_clr_tlb_mshr_o (cmd_clr_tlb_mshr),
		.cmd_clr_dmshr_o    (cmd_clr_dmshr),
		.cmd_tlb_flush_o    (cmd_tlb_flush),
		.cmd_sync_o         (cmd_sync),
		.flush_o            (flush_o),
		.abort_o            (abort_o),
		.stall_o            (stall_o),
		.trap_o             (trap_o),
		.trap_cause_o       (trap_cause_o),
		.retire_o           (retire_o)
	);

	maint_sequencer u_seq (
		.clk_i              (clk_i),
		.rst_n_i            (rst_n_i),
		.cmd_valid_i        (cmd_valid),
		.cmd_clr_tlb_mshr_i (cmd_clr_tlb_mshr),
		.cmd_clr_dmshr_i    (cmd_clr_dmshr),
		.cmd_tlb_flush_i    (cmd_tlb_flush),
		.cmd_sync_i         (cmd_sync),
		.seq_busy_o         (seq_busy),
		.clr_l1tlb_mshr_o   (clr_l1tlb_mshr_o),
		.clr_l2tlb_mshr_o   (clr_l2tlb_mshr_o),
		.clear_dmshr_o      (clear_dmshr_o),
		.l1tlb_flush_type_o (l1tlb_flush_type_o),
		.l2tlb_flush_type_o (l2tlb_flush_type_o),
		.synch_l1dc_l2c_o   (synch_l1dc_l2c_o),
		.l2c_update_done_i  (l2c_update_done_i)
	);

endmodule

// ==== hdl/maint_sequencer.sv ====
// Issues TLB/MSHR clears and the L1D to L2 sync, one command at a time
`timescale 1ns/1ps

module maint_sequencer (
	input  logic                clk_i,
	input  logic                rst_n_i,
	// Command from the control FSM
	input  logic                cmd_valid_i,
	input  logic                cmd_clr_tlb_mshr_i,
	input  logic                cmd_clr_dmshr_i,
	input  ctl_pkg::tlb_flush_e cmd_tlb_flush_i,
	input  logic                cmd_sync_i,
	output logic                seq_busy_o,
	// Memory system
	output logic                clr_l1tlb_mshr_o,
	output logic                clr_l2tlb_mshr_o,
	output logic                clear_dmshr_o,
	output ctl_pkg::tlb_flush_e l1tlb_flush_type_o,
	output ctl_pkg::tlb_flush_e l2tlb_flush_type_o,
	output logic                synch_l1dc_l2c_o,
	input  logic                l2c_update_done_i
);

	typedef enum logic [1:0] {
		IDLE,
		ISSUE,
		SYNC,
		DONE
	} state_t;

	state_t state;
	state_t next_state;

	// Latched command
	logic                clr_tlb_q;
	logic                clr_dmshr_q;
	ctl_pkg::tlb_flush_e tlb_flush_q;
	logic                sync_q;

	// Out of reset the unit issues the start-up clean-up on its own
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state       <= ISSUE;
			clr_tlb_q   <= 1'b1;
			clr_dmshr_q <= 1'b0;
			tlb_flush_q <= ctl_pkg::FLUSH_ALL;
			sync_q      <= 1'b0;
		end else begin
			state <= next_state;
			if ((state == IDLE) && cmd_valid_i) begin
				clr_tlb_q   <= cmd_clr_tlb_mshr_i;
				clr_dmshr_q <= cmd_clr_dmshr_i;
				tlb_flush_q <= cmd_tlb_flush_i;
				sync_q      <= cmd_sync_i;
			end
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			IDLE: begin
				if (cmd_valid_i) begin
					next_state = ISSUE;
				end
			end
			ISSUE: begin
				if (sync_q && !l2c_update_done_i) begin
					next_state = SYNC;
				end else begin
					next_state = DONE;
				end
			end
			SYNC: begin
				// L2 update latency is not fixed
				if (l2c_update_done_i) begin
					next_state = DONE;
				end
			end
			DONE: begin
				next_state = IDLE;
			end
			default: begin
				next_state = IDLE;
			end
		endcase
	end

	assign seq_busy_o = (state != IDLE);

	// One-cycle strobes in ISSUE
	assign clr_l1tlb_mshr_o   = (state == ISSUE) && clr_tlb_q;
	assign clr_l2tlb_mshr_o   = (state == ISSUE) && clr_tlb_q;
	assign clear_dmshr_o      = (state == ISSUE) && clr_dmshr_q;
	assign l1tlb_flush_type_o = (state == ISSUE) ? tlb_flush_q : ctl_pkg::NO_FLUSH;
	assign l2tlb_flush_type_o = (state == ISSUE) ? tlb_flush_q : ctl_pkg::NO_FLUSH;

	// Level request, held until the L2 reports completion
	assign synch_l1dc_l2c_o = ((state == ISSUE) && sync_q) || (state == SYNC);

endmodule

// ==== hdl/commit_ctl_fsm.sv ====
// Commit control FSM: classifies the queue head and raises flush, trap or maintenance
`timescale 1ns/1ps

module commit_ctl_fsm (
	input  logic                  clk_i,
	input  logic                  rst_n_i,
	// Queue head
	input  logic                  head_valid_i,
	input  ctl_pkg::instr_t       head_instr_i,
	input  logic                  head_except_i,
	input  ctl_pkg::except_code_t head_code_i,
	output logic                  head_pop_o,
	// Maintenance sequencer
	input  logic                  seq_busy_i,
	output logic                  cmd_valid_o,
	output logic                  cmd_clr_tlb_mshr_o,
	output logic                  cmd_clr_dmshr_o,
	output ctl_pkg::tlb_flush_e   cmd_tlb_flush_o,
	output logic                  cmd_sync_o,
	// Pipeline control
	output logic                  flush_o,
	output logic                  abort_o,
	output logic                  stall_o,
	output logic                  trap_o,
	output ctl_pkg::except_code_t trap_cause_o,
	output logic                  retire_o
);

	typedef enum logic [1:0] {
		RESET,
		RUN,
		WAIT_MAINT
	} state_t;

	state_t state;
	state_t next_state;

	ctl_pkg::opcode_t opcode;
	ctl_pkg::funct3_t funct3;
	ctl_pkg::funct7_t funct7;

	logic is_fence_i;
	logic is_sfence_vma;
	logic is_ecall;
	logic is_ebreak;

	// Decoded action of the head record
	logic                  dec_flush;
	logic                  dec_abort;
	logic                  dec_trap;
	ctl_pkg::except_code_t dec_cause;
	logic                  dec_clr_tlb;
	logic                  dec_clr_dmshr;
	ctl_pkg::tlb_flush_e   dec_tlb_flush;
	logic                  dec_sync;
	logic                  dec_retire;
	logic                  dec_cmd;

	// Head is consumed this cycle
	logic go;

	assign opcode = head_instr_i[6:0];
	assign funct3 = head_instr_i[14:12];
	assign funct7 = head_instr_i[31:25];

	assign is_fence_i    = (opcode == ctl_pkg::OPCODE_MISC_MEM) &&
	                       (funct3 == ctl_pkg::FUNCT3_FENCE_I);
	assign is_sfence_vma = (opcode == ctl_pkg::OPCODE_SYSTEM) &&
	                       (funct3 == ctl_pkg::FUNCT3_PRIV) &&
	                       (funct7 == ctl_pkg::FUNCT7_SFENCE_VMA);
	assign is_ecall      = (head_instr_i == ctl_pkg::INSTR_ECALL);
	assign is_ebreak     = (head_instr_i == ctl_pkg::INSTR_EBREAK);

	// Classification, first match wins
	always_comb begin
		dec_flush     = 1'b0;
		dec_abort     = 1'b0;
		dec_trap      = 1'b0;
		dec_cause     = '0;
		dec_clr_tlb   = 1'b0;
		dec_clr_dmshr = 1'b0;
		dec_tlb_flush = ctl_pkg::NO_FLUSH;
		dec_sync      = 1'b0;
		dec_retire    = 1'b0;
		if (head_except_i) begin
			case (head_code_i)
				ctl_pkg::E_I_MISALIGNED,
				ctl_pkg::E_I_ACCESS_FAULT,
				ctl_pkg::E_I_PAGE_FAULT: begin
					dec_flush   = 1'b1;
					dec_clr_tlb = 1'b1;
				end
				ctl_pkg::E_LD_MISALIGNED,
				ctl_pkg::E_LD_ACCESS_FAULT,
				ctl_pkg::E_ST_MISALIGNED,
				ctl_pkg::E_ST_ACCESS_FAULT,
				ctl_pkg::E_LD_PAGE_FAULT,
				ctl_pkg::E_ST_PAGE_FAULT: begin
					dec_flush     = 1'b1;
					dec_clr_dmshr = 1'b1;
				end
				ctl_pkg::E_ILLEGAL_INSTR: begin
					dec_flush = 1'b1;
					dec_abort = 1'b1;
				end
				default: begin
					dec_trap  = 1'b1;
					dec_cause = head_code_i;
				end
			endcase
		end else if (is_fence_i) begin
			dec_clr_tlb = 1'b1;
		end else if (is_sfence_vma) begin
			// Drop translations and write back L1D before anything younger commits
			dec_clr_tlb   = 1'b1;
			dec_clr_dmshr = 1'b1;
			dec_tlb_flush = ctl_pkg::FLUSH_ALL;
			dec_sync      = 1'b1;
		end else if (is_ecall) begin
			dec_trap  = 1'b1;
			dec_cause = ctl_pkg::E_ECALL_U;
		end else if (is_ebreak) begin
			dec_trap  = 1'b1;
			dec_cause = ctl_pkg::E_BREAKPOINT;
		end else begin
			dec_retire = 1'b1;
		end
	end

	assign dec_cmd = dec_clr_tlb || dec_clr_dmshr || dec_sync ||
	                 (dec_tlb_flush != ctl_pkg::NO_FLUSH);

	// Hold off while the start-up clean-up is still running
	assign go = (state == RUN) && head_valid_i && !seq_busy_i;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state <= RESET;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			RESET: begin
				next_state = RUN;
			end
			RUN: begin
				if (go && dec_cmd) begin
					next_state = WAIT_MAINT;
				end
			end
			WAIT_MAINT: begin
				if (!seq_busy_i) begin
					next_state = RUN;
				end
			end
			default: begin
				next_state = RESET;
			end
		endcase
	end

	// Outputs
	assign head_pop_o = go;
	assign stall_o    = (state == WAIT_MAINT);
	assign flush_o    = (state == RESET) || (go && dec_flush);
	assign abort_o    = go && dec_abort;
	assign trap_o     = go && dec_trap;
	assign trap_cause_o = dec_cause;
	assign retire_o   = go && dec_retire;

	assign cmd_valid_o        = go && dec_cmd;
	assign cmd_clr_tlb_mshr_o = dec_clr_tlb;
	assign cmd_clr_dmshr_o    = dec_clr_dmshr;
	assign cmd_tlb_flush_o    = dec_tlb_flush;
	assign cmd_sync_o         = dec_sync;

endmodule

// ==== hdl/commit_queue.sv ====
// Credit-controlled FIFO that buffers commit records ahead of the control FSM
`timescale 1ns/1ps

module commit_queue (
	input  logic                  clk_i,
	input  logic                  rst_n_i,
	// Sender side
	input  logic                  rec_valid_i,
	input  ctl_pkg::instr_t       rec_instr_i,
	input  logic                  rec_except_i,
	input  ctl_pkg::except_code_t rec_code_i,
	// Head of queue towards the FSM
	input  logic                  head_pop_i,
	output logic                  head_valid_o,
	output ctl_pkg::instr_t       head_instr_o,
	output logic                  head_except_o,
	output ctl_pkg::except_code_t head_code_o,
	// One pulse per freed entry
	output logic                  credit_o
);

	ctl_pkg::record_t mem [ctl_pkg::CQ_DEPTH];

	ctl_pkg::cq_ptr_t          wr_ptr;
	ctl_pkg::cq_ptr_t          rd_ptr;
	logic [ctl_pkg::CQ_PTR_W:0] count;

	ctl_pkg::record_t wr_rec;
	ctl_pkg::record_t head_rec;
	logic             push;
	logic             pop;

	function automatic ctl_pkg::cq_ptr_t ptr_inc(input ctl_pkg::cq_ptr_t ptr);
		if (ptr == ctl_pkg::cq_ptr_t'(ctl_pkg::CQ_DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	// Sender only writes with a credit in hand, so no full check here
	assign push   = rec_valid_i;
	assign pop    = head_pop_i && head_valid_o;
	assign wr_rec = {rec_instr_i, rec_except_i, rec_code_i};

	assign head_valid_o = (count != '0);
	assign head_rec     = mem[rd_ptr];
	assign {head_instr_o, head_except_o, head_code_o} = head_rec;

	// Record storage
	always_ff @(posedge clk_i) begin
		if (push) begin
			mem[wr_ptr] <= wr_rec;
		end
	end

	// Pointers, occupancy and credit return
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			credit_o <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			// Credit goes back one cycle after the pop
			credit_o <= pop;
		end
	end

endmodule

// ==== hdl/ctl_pkg.sv ====
// Shared widths, opcodes, cause codes and queue sizing for the commit control unit
package ctl_pkg;

	// Instruction fields
	typedef logic [31:0] instr_t;
	typedef logic [6:0]  opcode_t;
	typedef logic [2:0]  funct3_t;
	typedef logic [6:0]  funct7_t;

	// RISC-V exception cause, low four bits of mcause
	typedef logic [3:0]  except_code_t;

	// TLB flush request type
	typedef enum logic [1:0] {
		NO_FLUSH   = 2'd0,
		FLUSH_ALL  = 2'd1,
		FLUSH_ASID = 2'd2
	} tlb_flush_e;

	// Major opcodes
	localparam opcode_t OPCODE_SYSTEM   = 7'b1110011;
	localparam opcode_t OPCODE_MISC_MEM = 7'b0001111;
	localparam opcode_t OPCODE_LOAD     = 7'b0000011;

	// Minor opcodes
	localparam funct3_t FUNCT3_FENCE_I = 3'd1;
	localparam funct3_t FUNCT3_PRIV    = 3'd0;

	// Full encodings of the environment instructions
	localparam instr_t  INSTR_ECALL       = 32'h0000_0073;
	localparam instr_t  INSTR_EBREAK      = 32'h0010_0073;
	localparam funct7_t FUNCT7_SFENCE_VMA = 7'h09;

	// Exception causes
	localparam except_code_t E_I_MISALIGNED   = 4'd0;
	localparam except_code_t E_I_ACCESS_FAULT = 4'd1;
	localparam except_code_t E_ILLEGAL_INSTR  = 4'd2;
	localparam except_code_t E_BREAKPOINT     = 4'd3;
	localparam except_code_t E_LD_MISALIGNED  = 4'd4;
	localparam except_code_t E_LD_ACCESS_FAULT = 4'd5;
	localparam except_code_t E_ST_MISALIGNED  = 4'd6;
	localparam except_code_t E_ST_ACCESS_FAULT = 4'd7;
	localparam except_code_t E_ECALL_U        = 4'd8;
	localparam except_code_t E_ECALL_S        = 4'd9;
	localparam except_code_t E_ECALL_M        = 4'd11;
	localparam except_code_t E_I_PAGE_FAULT   = 4'd12;
	localparam except_code_t E_LD_PAGE_FAULT  = 4'd13;
	localparam except_code_t E_ST_PAGE_FAULT  = 4'd15;

	// Commit queue sizing, also the sender's credit count after reset
	localparam int CQ_DEPTH = 4;
	localparam int CQ_PTR_W = 2;
	localparam int RECORD_W = 37;

	typedef logic [CQ_PTR_W-1:0] cq_ptr_t;

	// Instruction, exception flag, cause
	typedef logic [RECORD_W-1:0] record_t;

endpackage
